//--- sources.f
+incdir+verif
hw/csrTypesPkg.sv
hw/csrMapPkg.sv
hw/csrCounters.sv
hw/csrPinsIds.sv
hw/csrReadMerge.sv
hw/csrBank.sv
verif/csrBankTb.sv

//--- verif/csrBankVectors.svh
// Access table for the CSR bank testbench with one stimulus and expected answer per row
`ifndef CSR_BANK_VECTORS_SVH
`define CSR_BANK_VECTORS_SVH

// Only fixed rows take rdata, valid and pins from the table
localparam int kindFixed   = 0;
localparam int kindPins    = 1;   // Random wdata and pinsIn with the answer from the pin rules
localparam int kindCycle   = 2;   // Cycle count at the execute cycle
localparam int kindInstret = 3;   // Running total of retired pulses

task automatic loadVectors;
    // Columns name, addr, modify, wdata, pinsIn, pulses, rdata, valid, pinsOut, kind
    addVector("vendor id", addrVendorId, modifyNone, 0, 0, 0, vendorId, 1, 'h01, kindFixed);
    addVector("arch id", addrArchId, modifyNone, 0, 0, 0, archId, 1, 'h01, kindFixed);
    addVector("imp id", addrImpId, modifyNone, 0, 0, 0, impId, 1, 'h01, kindFixed);
    addVector("hart id", addrHartId, modifyNone, 0, 0, 0, hartId, 1, 'h01, kindFixed);
    addVector("khz", addrKhz, modifyNone, 0, 0, 0, clockKhz, 1, 'h01, kindFixed);
    addVector("unmapped 000", 12'h000, modifyNone, 0, 0, 0, 0, 0, 'h01, kindFixed);
    addVector("unmapped 7ff", 12'h7FF, modifyNone, 0, 0, 0, 0, 0, 'h01, kindFixed);
    // Read-only ID keeps its value
    addVector("id write", addrVendorId, modifyWrite, 'hFFFF_FFFF, 0, 0, vendorId, 1, 'h01,
              kindFixed);
    addVector("id after write", addrVendorId, modifyNone, 0, 0, 0, vendorId, 1, 'h01,
              kindFixed);

    // Counters
    addVector("instret", addrInstret, modifyNone, 0, 0, 3, 0, 0, 0, kindInstret);
    addVector("minstret", addrMinstret, modifyNone, 0, 0, 2, 0, 0, 0, kindInstret);
    addVector("instreth", addrInstretH, modifyNone, 0, 0, 1, 0, 1, 'h01, kindFixed);
    addVector("minstreth", addrMinstretH, modifyNone, 0, 0, 0, 0, 1, 'h01, kindFixed);
    addVector("cycle", addrCycle, modifyNone, 0, 0, 0, 0, 0, 0, kindCycle);
    addVector("mcycle", addrMcycle, modifyNone, 0, 0, 0, 0, 0, 0, kindCycle);
    addVector("time", addrTime, modifyNone, 0, 0, 0, 0, 0, 0, kindCycle);
    addVector("cycle later", addrCycle, modifyNone, 0, 0, 2, 0, 0, 0, kindCycle);
    addVector("cycleh", addrCycleH, modifyNone, 0, 0, 0, 0, 1, 'h01, kindFixed);
    addVector("mcycleh", addrMcycleH, modifyNone, 0, 0, 0, 0, 1, 'h01, kindFixed);
    addVector("timeh", addrTimeH, modifyNone, 0, 0, 0, 0, 1, 'h01, kindFixed);

    // Output pin writes answer with valid low
    addVector("pins reset", addrPinsOut, modifyNone, 0, 0, 0, 'h01, 1, 'h01, kindFixed);
    addVector("pins write", addrPinsOut, modifyWrite, 'hA5, 0, 0, 0, 0, 'hA5, kindFixed);
    addVector("pins set", addrPinsOut, modifySet, 'h10, 0, 0, 0, 0, 'hB5, kindFixed);
    addVector("pins clear", addrPinsOut, modifyClear, 'h05, 0, 0, 0, 0, 'hB0, kindFixed);
    addVector("pins read", addrPinsOut, modifyNone, 0, 0, 0, 'hB0, 1, 'hB0, kindFixed);
    addVector("pins in a", addrPinsIn, modifyNone, 0, 0, 0, 0, 0, 0, kindPins);
    addVector("pins in b", addrPinsIn, modifyNone, 0, 0, 0, 0, 0, 0, kindPins);
    addVector("rnd write", addrPinsOut, modifyWrite, 0, 0, 0, 0, 0, 0, kindPins);
    addVector("rnd set", addrPinsOut, modifySet, 0, 0, 0, 0, 0, 0, kindPins);
    addVector("rnd clear", addrPinsOut, modifyClear, 0, 0, 0, 0, 0, 0, kindPins);
    addVector("rnd read", addrPinsOut, modifyNone, 0, 0, 0, 0, 0, 0, kindPins);
    addVector("instret end", addrInstret, modifyNone, 0, 0, 1, 0, 0, 0, kindInstret);
endtask

`endif

//--- verif/csrBankTb.sv
// Testbench for the CSR bank that checks table-driven accesses against the pipeline timing
`timescale 1ns/10ps

module csrBankTb
    import csrTypesPkg::*;
    import csrMapPkg::*;
();

    logic      clk;
    logic      rstn;
    csrAddrT   addr;
    logic      read;
    csrModifyT modify;
    csrDataT   wdata;
    csrDataT   rdata;
    logic      valid;
    logic      retired;
    pinsInT    pinsIn;
    pinsOutT   pinsOut;

    localparam csrAddrT idleAddr = 12'h000;  // Unmapped address decodes to nothing

    // Table columns
    string     names[$];
    csrAddrT   addrs[$];
    csrModifyT modifies[$];
    csrDataT   wdatas[$];
    pinsInT    pinsIns[$];
    int        pulseCounts[$];
    csrDataT   expDatas[$];
    logic      expValids[$];
    pinsOutT   expPinsList[$];
    int        kinds[$];

    int      cycleNow;    // Clock cycles since reset release
    int      pulseTotal;
    pinsOutT pinsModel;   // Output pins as the modify rules predict
    int      passCount;
    int      failCount;
    logic    tableReady;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    csrBank u_csrBank (
        .clk     (clk),
        .rstn    (rstn),
        .addr    (addr),
        .read    (read),
        .modify  (modify),
        .wdata   (wdata),
        .retired (retired),
        .pinsIn  (pinsIn),
        .pinsOut (pinsOut),
        .rdata   (rdata),
        .valid   (valid)
    );

    task automatic addVector(input string name, input csrAddrT rowAddr, input csrModifyT rowMod,
                             input csrDataT rowWdata, input int rowPins, input int pulses,
                             input csrDataT expData, input int expValid, input int expPins,
                             input int kind);
        names.push_back(name);
        addrs.push_back(rowAddr);
        modifies.push_back(rowMod);
        wdatas.push_back(rowWdata);
        pinsIns.push_back(pinsInT'(rowPins));
        pulseCounts.push_back(pulses);
        expDatas.push_back(expData);
        expValids.push_back(expValid != 0);
        expPinsList.push_back(pinsOutT'(expPins));
        kinds.push_back(kind);
    endtask

    `include "csrBankVectors.svh"

    task automatic stepCycle;
        @(negedge clk);
        cycleNow++;
    endtask

    // Output-pin update as defined for each modify code
    function automatic pinsOutT applyModify(input pinsOutT old, input csrModifyT code,
                                            input csrDataT value);
        pinsOutT bits;
        bits = value[pinsOutCount-1:0];
        case (code)
            modifyWrite: return bits;
            modifySet:   return old | bits;
            modifyClear: return old & ~bits;
            default:     return old;
        endcase
    endfunction

    task automatic reportTest(input string name, input csrDataT expData, input csrDataT gotData,
                              input logic expValid, input logic gotValid,
                              input pinsOutT expPins, input pinsOutT gotPins);
        if (gotData !== expData || gotValid !== expValid || gotPins !== expPins) begin
            failCount++;
            $display("FAIL %s: expected data %h valid %b pins %h, actual data %h valid %b pins %h",
                     name, expData, expValid, expPins, gotData, gotValid, gotPins);
        end else begin
            passCount++;
            $display("PASS %s", name);
        end
    endtask

    // One access on its own from falling edge to falling edge
    task automatic runEntry(input int idx);
        int      issue;
        csrDataT wd;
        pinsInT  pi;
        pinsOutT gotPins;
        csrDataT expData;
        logic    expValid;
        pinsOutT expPins;
        wd = wdatas[idx];
        pi = pinsIns[idx];
        if (kinds[idx] == kindPins) begin
            wd = $urandom;
            pi = pinsInT'($urandom);
        end
        repeat (pulseCounts[idx]) begin
            retired = 1'b1;
            stepCycle();
            retired = 1'b0;
            stepCycle();
        end
        pulseTotal += pulseCounts[idx];
        issue = cycleNow;
        addr = addrs[idx];
        pinsIn = pi;
        stepCycle();
        addr = idleAddr;
        modify = modifies[idx];
        wdata = wd;
        read = 1'b1;
        stepCycle();
        modify = modifyNone;
        wdata = '0;
        read = 1'b0;
        gotPins = pinsOut;  // Write has landed on edge 2
        stepCycle();
        if (addrs[idx] == addrPinsOut && modifies[idx] != modifyNone) begin
            pinsModel = applyModify(pinsModel, modifies[idx], wd);
        end
        expValid = 1'b1;
        expPins = pinsModel;
        case (kinds[idx])
            kindCycle:   expData = csrDataT'(issue + 1);  // Decode edge already counted
            kindInstret: expData = csrDataT'(pulseTotal);
            kindPins: begin
                if (addrs[idx] == addrPinsIn) begin
                    expData = csrDataT'(pi);
                end else if (modifies[idx] == modifyNone) begin
                    expData = csrDataT'(pinsModel);
                end else begin
                    expData = '0;
                    expValid = 1'b0;
                end
            end
            default: begin
                expData = expDatas[idx];
                expValid = expValids[idx];
                expPins = expPinsList[idx];
            end
        endcase
        reportTest(names[idx], expData, rdata, expValid, valid, expPins, gotPins);
    endtask

    // Fixed rows issued back to back with three accesses in flight
    task automatic runBurst;
        int order[$];
        int total;
        int row;
        for (int i = 0; i < names.size(); i++) begin
            if (kinds[i] == kindFixed && addrs[i] != addrPinsOut) begin
                order.push_back(i);
            end
        end
        total = order.size();
        for (int step = 0; step < total + 3; step++) begin
            if (step >= 3) begin
                row = order[step-3];
                reportTest({"burst ", names[row]}, expDatas[row], rdata, expValids[row], valid,
                           pinsModel, pinsOut);
            end
            addr = (step < total) ? addrs[order[step]] : idleAddr;
            if (step >= 1 && step <= total) begin
                modify = modifies[order[step-1]];
                wdata = wdatas[order[step-1]];
                read = 1'b1;
            end else begin
                modify = modifyNone;
                wdata = '0;
                read = 1'b0;
            end
            stepCycle();
        end
    endtask

    initial begin
        rstn = 1'b0;
        addr = idleAddr;
        read = 1'b0;
        modify = modifyNone;
        wdata = '0;
        retired = 1'b0;
        pinsIn = '0;
        cycleNow = 0;
        pulseTotal = 0;
        passCount = 0;
        failCount = 0;
        pinsModel = pinsOutResetValue;
        tableReady = 1'b0;
        void'($urandom(32'h906a));
        loadVectors();
        tableReady = 1'b1;

        repeat (3) @(negedge clk);
        rstn = 1'b1;
        reportTest("reset", '0, rdata, 1'b0, valid, pinsOutResetValue, pinsOut);

        for (int i = 0; i < names.size(); i++) begin
            runEntry(i);
        end
        runBurst();

        $display("Tests run %0d, passed %0d, failed %0d", passCount + failCount, passCount,
                 failCount);
        if (failCount == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog with a bound per table row
    initial begin
        int limit;
        wait (tableReady === 1'b1);
        limit = names.size() * 12 + 100;
        repeat (limit) @(posedge clk);
        $display("Timeout: the access sequence did not finish within %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- hw/csrBank.sv
// Processor-side CSR bank with counters, IDs and pin registers in three stages
`timescale 1ns/10ps

module csrBank
    import csrTypesPkg::*;
    import csrMapPkg::*;
(
    input  logic      clk,
    input  logic      rstn,

    // Core access, addr in decode cycle, modify and wdata one cycle later
    input  csrAddrT   addr,
    input  logic      read,      // Reads have no side effect in this bank
    input  csrModifyT modify,
    input  csrDataT   wdata,
    output csrDataT   rdata,     // Answers the addr of three cycles earlier
    output logic      valid,

    input  logic      retired,

    input  pinsInT    pinsIn,    // Switches
    output pinsOutT   pinsOut    // LEDs
);

    // Block answers towards the merge stage
    csrDataT counterData;
    logic    counterValid;
    csrDataT pinsData;
    logic    pinsValid;

    csrCounters u_csrCounters (
        .clk          (clk),
        .rstn         (rstn),
        .addr         (addr),
        .retired      (retired),
        .counterData  (counterData),
        .counterValid (counterValid)
    );

    csrPinsIds u_csrPinsIds (
        .clk       (clk),
        .rstn      (rstn),
        .addr      (addr),
        .modify    (modify),
        .wdata     (wdata),
        .pinsIn    (pinsIn),
        .pinsOut   (pinsOut),
        .pinsData  (pinsData),
        .pinsValid (pinsValid)
    );

    // Final stage
    csrReadMerge u_csrReadMerge (
        .clk          (clk),
        .rstn         (rstn),
        .counterData  (counterData),
        .counterValid (counterValid),
        .pinsData     (pinsData),
        .pinsValid    (pinsValid),
        .rdata        (rdata),
        .valid        (valid)
    );

endmodule

//--- hw/csrReadMerge.sv
// Third CSR pipeline stage, merges the block answers into one registered result
`timescale 1ns/10ps

module csrReadMerge
    import csrTypesPkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  csrDataT counterData,
    input  logic    counterValid,
    input  csrDataT pinsData,
    input  logic    pinsValid,
    output csrDataT rdata,
    output logic    valid
);

    // Unselected blocks drive zero, so OR is the mux
    csrDataT mergedData;
    logic    mergedValid;

    assign mergedData  = counterData | pinsData;
    assign mergedValid = counterValid | pinsValid;

    // Registering here keeps the read mux out of the execute path
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rdata <= '0;
            valid <= 1'b0;
        end else begin
            rdata <= mergedData;
            valid <= mergedValid;
        end
    end

endmodule

//--- hw/csrPinsIds.sv
// ID, clock-rate and pin registers with decode, read and write stage
`timescale 1ns/10ps

module csrPinsIds
    import csrTypesPkg::*;
    import csrMapPkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  csrAddrT   addr,
    input  csrModifyT modify,     // Valid one cycle after addr
    input  csrDataT   wdata,
    input  pinsInT    pinsIn,
    output pinsOutT   pinsOut,
    output csrDataT   pinsData,
    output logic      pinsValid
);

    // Registered enables, one per register
    logic enVendor;
    logic enArch;
    logic enImp;
    logic enHart;
    logic enKhz;
    logic enPinsIn;
    logic enPinsOut;

    pinsOutT pinsOutQ;

    logic    pinsOutWrite;   // Output-pin access that modifies
    logic    pinsOutRead;
    logic    anyReadable;
    csrDataT readWord;

    // Decode stage
    always_ff @(posedge clk) begin
        if (!rstn) begin
            enVendor  <= 1'b0;
            enArch    <= 1'b0;
            enImp     <= 1'b0;
            enHart    <= 1'b0;
            enKhz     <= 1'b0;
            enPinsIn  <= 1'b0;
            enPinsOut <= 1'b0;
        end else begin
            enVendor  <= (addr == addrVendorId);
            enArch    <= (addr == addrArchId);
            enImp     <= (addr == addrImpId);
            enHart    <= (addr == addrHartId);
            enKhz     <= (addr == addrKhz);
            enPinsIn  <= (addr == addrPinsIn);
            enPinsOut <= (addr == addrPinsOut);
        end
    end

    assign pinsOutWrite = enPinsOut && (modify != modifyNone);
    assign pinsOutRead  = enPinsOut && (modify == modifyNone);

    // Writes to the output pins report no valid
    assign anyReadable = enVendor | enArch | enImp | enHart | enKhz | enPinsIn | pinsOutRead;

    always_comb begin
        readWord = '0;
        if (enVendor)    readWord = readWord | vendorId;
        if (enArch)      readWord = readWord | archId;
        if (enImp)       readWord = readWord | impId;
        if (enHart)      readWord = readWord | hartId;
        if (enKhz)       readWord = readWord | clockKhz;
        if (enPinsIn)    readWord = readWord | csrDataT'(pinsIn);
        if (pinsOutRead) readWord = readWord | csrDataT'(pinsOutQ);
    end

    // Read stage
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pinsData  <= '0;
            pinsValid <= 1'b0;
        end else begin
            pinsData  <= readWord;
            pinsValid <= anyReadable;
        end
    end

    // Write stage for the output pins, other modify codes are ignored
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pinsOutQ <= pinsOutResetValue;
        end else if (pinsOutWrite) begin
            case (modify)
                modifyWrite: pinsOutQ <= wdata[pinsOutCount-1:0];
                modifySet:   pinsOutQ <= pinsOutQ | wdata[pinsOutCount-1:0];
                modifyClear: pinsOutQ <= pinsOutQ & ~wdata[pinsOutCount-1:0];
                default:     pinsOutQ <= pinsOutQ;
            endcase
        end
    end

    assign pinsOut = pinsOutQ;

endmodule

//--- hw/csrCounters.sv
// Cycle and retired-instruction counters with a decode and read stage
`timescale 1ns/10ps

module csrCounters
    import csrTypesPkg::*;
    import csrMapPkg::*;
(
    input  logic    clk,
    input  logic    rstn,
    input  csrAddrT addr,
    input  logic    retired,        // One pulse per retired instruction
    output csrDataT counterData,
    output logic    counterValid
);

    // Address hits, evaluated in the decode cycle
    logic hitCycleL;
    logic hitCycleH;
    logic hitInstretL;
    logic hitInstretH;

    // Registered enables for the execute cycle
    logic enCycleL;
    logic enCycleH;
    logic enInstretL;
    logic enInstretH;

    // Counters, low halves keep their carry for one cycle
    counterT cycleLow;
    csrDataT cycleHigh;
    counterT instretLow;
    csrDataT instretHigh;

    csrDataT readWord;
    logic    anyEnable;

    assign hitCycleL   = (addr == addrMcycle) || (addr == addrCycle) || (addr == addrTime);
    assign hitCycleH   = (addr == addrMcycleH) || (addr == addrCycleH) || (addr == addrTimeH);
    assign hitInstretL = (addr == addrMinstret) || (addr == addrInstret);
    assign hitInstretH = (addr == addrMinstretH) || (addr == addrInstretH);

    // Decode stage
    always_ff @(posedge clk) begin
        if (!rstn) begin
            enCycleL   <= 1'b0;
            enCycleH   <= 1'b0;
            enInstretL <= 1'b0;
            enInstretH <= 1'b0;
        end else begin
            enCycleL   <= hitCycleL;
            enCycleH   <= hitCycleH;
            enInstretL <= hitInstretL;
            enInstretH <= hitInstretH;
        end
    end

    // Counting is split over two cycles to keep the adders short
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cycleLow    <= '0;
            cycleHigh   <= '0;
            instretLow  <= '0;
            instretHigh <= '0;
        end else begin
            cycleLow    <= {1'b0, cycleLow[csrDataWidth-1:0]} + counterT'(1);
            cycleHigh   <= cycleHigh + csrDataT'(cycleLow[csrDataWidth]);
            instretLow  <= {1'b0, instretLow[csrDataWidth-1:0]} + counterT'(retired);
            instretHigh <= instretHigh + csrDataT'(instretLow[csrDataWidth]);
        end
    end

    // At most one enable is set, so the words can be ORed
    always_comb begin
        readWord = '0;
        if (enCycleL) begin
            readWord = readWord | cycleLow[csrDataWidth-1:0];
        end
        if (enCycleH) begin
            readWord = readWord | cycleHigh;
        end
        if (enInstretL) begin
            readWord = readWord | instretLow[csrDataWidth-1:0];
        end
        if (enInstretH) begin
            readWord = readWord | instretHigh;
        end
    end

    assign anyEnable = enCycleL | enCycleH | enInstretL | enInstretH;

    // Read stage, zero when no counter is addressed
    always_ff @(posedge clk) begin
        if (!rstn) begin
            counterData  <= '0;
            counterValid <= 1'b0;
        end else begin
            counterData  <= readWord;
            counterValid <= anyEnable;
        end
    end

endmodule

//--- hw/csrMapPkg.sv
// CSR address map, ID constants, clock rate and pin counts of the CSR bank
package csrMapPkg;

    import csrTypesPkg::*;

    // Machine ID registers
    localparam csrAddrT addrVendorId = 12'hF11;
    localparam csrAddrT addrArchId   = 12'hF12;
    localparam csrAddrT addrImpId    = 12'hF13;
    localparam csrAddrT addrHartId   = 12'hF14;

    // Board-specific registers
    localparam csrAddrT addrKhz      = 12'hFC0;  // Clock frequency in kHz
    localparam csrAddrT addrPinsIn   = 12'hFC1;  // Switches
    localparam csrAddrT addrPinsOut  = 12'hBC1;  // LEDs

    // Cycle counter, TIME aliases the cycle count
    localparam csrAddrT addrMcycle   = 12'hB00;
    localparam csrAddrT addrCycle    = 12'hC00;
    localparam csrAddrT addrTime     = 12'hC01;
    localparam csrAddrT addrMcycleH  = 12'hB80;
    localparam csrAddrT addrCycleH   = 12'hC80;
    localparam csrAddrT addrTimeH    = 12'hC81;

    // Retired-instruction counter
    localparam csrAddrT addrMinstret  = 12'hB02;
    localparam csrAddrT addrInstret   = 12'hC02;
    localparam csrAddrT addrMinstretH = 12'hB82;
    localparam csrAddrT addrInstretH  = 12'hC82;

    localparam csrDataT vendorId = 32'h0000_0A5C;
    localparam csrDataT archId   = 32'h0000_0023;
    localparam csrDataT impId    = 32'h0001_0200;
    localparam csrDataT hartId   = 32'h0000_0000;  // Single hart

    localparam csrDataT clockRateHz = 32'd12_000_000;
    localparam csrDataT clockKhz    = clockRateHz / 1000;

    localparam int pinsOutCount = 8;
    localparam int pinsInCount  = 8;

    typedef logic [pinsOutCount-1:0] pinsOutT;
    typedef logic [pinsInCount-1:0]  pinsInT;

    localparam pinsOutT pinsOutResetValue = 8'h01;  // First LED lit after reset

endpackage

//--- hw/csrTypesPkg.sv
// CSR bus types: field widths, vector typedefs and modify-operation codes
package csrTypesPkg;

    // Field widths of the CSR access bus
    localparam int csrAddrWidth   = 12;
    localparam int csrDataWidth   = 32;
    localparam int csrModifyWidth = 3;

    typedef logic [csrAddrWidth-1:0]   csrAddrT;
    typedef logic [csrDataWidth-1:0]   csrDataT;
    typedef logic [csrModifyWidth-1:0] csrModifyT;

    // Low counter half plus carry bit into the high word
    typedef logic [csrDataWidth:0] counterT;

    // Modify field as presented by the core in the execute cycle
    localparam csrModifyT modifyNone  = 3'b000;  // Plain read
    localparam csrModifyT modifyWrite = 3'b001;
    localparam csrModifyT modifySet   = 3'b010;  // OR wdata into register
    localparam csrModifyT modifyClear = 3'b011;  // Mask wdata out of register

endpackage
